//--- iic_defines.svh
`ifndef IIC_DEFINES_SVH
`define IIC_DEFINES_SVH

// Register window base, decoded over 16 bytes.
`define IIC_BASEADDR 32'h0000_0000

// Word offsets inside the window.
`define IIC_REG_OP     2'd0
`define IIC_REG_RX     2'd1
`define IIC_REG_STATUS 2'd2

// Queue depths, powers of two.
`define IIC_OP_DEPTH 16
`define IIC_RX_DEPTH 16

// OPB_Clk cycles per quarter of an SCL period.
`define IIC_QTR_CYCLES 4

`endif

//--- iic_pkg.sv
package iic_pkg;

  // One queued operation word, stop flag in the top bit.
  typedef struct packed {
    logic       stop;   // STOP after this byte.
    logic       start;  // START before this byte.
    logic       rnw;    // Read a byte from the slave.
    logic [7:0] data;   // Byte to write.
  } iic_op_s;

  // The queue carries the raw word, the engine decodes the fields.
  typedef union packed {
    iic_op_s     f;
    logic [10:0] raw;
  } iic_op_u;

  // Bit positions in the status register.
  typedef enum int unsigned {
    stat_rx_empty = 0,
    stat_rx_full  = 1,
    stat_rx_over  = 2,
    stat_op_empty = 4,
    stat_op_full  = 5,
    stat_op_over  = 6,
    stat_nack_err = 8
  } iic_stat_bit_e;

endpackage

//--- iic_sync_fifo.sv
`timescale 1ns/10ps

module iic_sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             OPB_Clk,
  input  logic             rst_n_i,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             overflow_o
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW:0]      wr_ptr;
  logic [AW:0]      rd_ptr;
  logic             head_vld;
  logic             mem_empty;
  logic             do_write;
  logic             load_head;

  assign mem_empty = wr_ptr == rd_ptr;
  assign full_o    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty_o   = !head_vld;
  assign do_write  = wr_en_i && !full_o;  // Writes while full are lost.

  // Refill the head register when it is free or being read out.
  assign load_head = !mem_empty && (!head_vld || rd_en_i);

  always_ff @(posedge OPB_Clk) begin
    if (do_write) begin
      mem[wr_ptr[AW-1:0]] <= din_i;
    end
    if (load_head) begin
      dout_o <= mem[rd_ptr[AW-1:0]];  // Head register holds one entry beyond DEPTH.
    end
  end

  always_ff @(posedge OPB_Clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      head_vld   <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= wr_en_i && full_o;
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load_head) begin
        rd_ptr   <= rd_ptr + 1'b1;
        head_vld <= 1'b1;
      end else if (rd_en_i) begin
        head_vld <= 1'b0;  // Last entry read out.
      end
    end
  end

endmodule

//--- iic_opb_attach.sv
`timescale 1ns/10ps
`include "iic_defines.svh"

module iic_opb_attach import iic_pkg::*; (
  input  logic        OPB_Clk,
  input  logic        rst_n_i,
  input  logic [31:0] opb_abus_i,
  input  logic [31:0] opb_dbus_i,
  input  logic        opb_rnw_i,
  input  logic [3:0]  opb_be_i,
  input  logic        opb_select_i,
  output logic [31:0] sl_dbus_o,
  output logic        sl_xferack_o,
  output logic        op_push_o,
  output iic_op_u     op_word_o,
  output logic        rx_pop_o,
  input  logic [7:0]  rx_data_i,
  input  logic        op_empty_i,
  input  logic        op_full_i,
  input  logic        op_over_i,
  input  logic        rx_empty_i,
  input  logic        rx_full_i,
  input  logic        rx_over_i,
  input  logic        nack_i
);

  logic        addr_match;
  logic [1:0]  reg_idx;
  logic        req;
  logic        push_d;
  logic        pop_d;
  logic        clr_d;
  logic        op_over_q;
  logic        rx_over_q;
  logic        nack_q;
  logic [31:0] stat_word;
  logic [31:0] rd_word;

  assign addr_match = (opb_abus_i & 32'hFFFF_FFF0) == `IIC_BASEADDR;
  assign reg_idx    = opb_abus_i[3:2];
  assign req        = opb_select_i && addr_match && !sl_xferack_o;  // No back-to-back acks.

  assign push_d = req && !opb_rnw_i && opb_be_i[0] && (reg_idx == `IIC_REG_OP);
  assign pop_d  = req && opb_rnw_i && opb_be_i[0] && (reg_idx == `IIC_REG_RX);
  assign clr_d  = req && !opb_rnw_i && (reg_idx == `IIC_REG_STATUS);

  // Master holds the data bus through the ack cycle.
  assign op_word_o = iic_op_u'(opb_dbus_i[10:0]);

  always_ff @(posedge OPB_Clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sl_xferack_o <= 1'b0;
      op_push_o    <= 1'b0;
      rx_pop_o     <= 1'b0;
      op_over_q    <= 1'b0;
      rx_over_q    <= 1'b0;
      nack_q       <= 1'b0;
    end else begin
      sl_xferack_o <= req;
      op_push_o    <= push_d;
      rx_pop_o     <= pop_d;
      // Clearing wins over a new event.
      op_over_q    <= clr_d ? 1'b0 : (op_over_q | op_over_i);
      rx_over_q    <= clr_d ? 1'b0 : (rx_over_q | rx_over_i);
      nack_q       <= clr_d ? 1'b0 : (nack_q | nack_i);
    end
  end

  always_comb begin
    stat_word                = '0;
    stat_word[stat_rx_empty] = rx_empty_i;
    stat_word[stat_rx_full]  = rx_full_i;
    stat_word[stat_rx_over]  = rx_over_q;
    stat_word[stat_op_empty] = op_empty_i;
    stat_word[stat_op_full]  = op_full_i;
    stat_word[stat_op_over]  = op_over_q;
    stat_word[stat_nack_err] = nack_q;
  end

  always_comb begin
    case (reg_idx)
      `IIC_REG_RX:     rd_word = {24'b0, rx_data_i};  // Head before the pop.
      `IIC_REG_STATUS: rd_word = stat_word;
      default:         rd_word = '0;
    endcase
  end

  assign sl_dbus_o = (sl_xferack_o && opb_rnw_i) ? rd_word : '0;

endmodule

//--- iic_byte_engine.sv
`timescale 1ns/10ps
`include "iic_defines.svh"

module iic_byte_engine import iic_pkg::*; (
  input  logic       OPB_Clk,
  input  logic       rst_n_i,
  input  logic       op_valid_i,
  input  iic_op_u    op_word_i,
  output logic       op_ack_o,
  output logic [7:0] rd_data_o,
  output logic       nack_o,
  input  logic       sda_i,
  output logic       sda_o,
  output logic       sda_t_o,
  input  logic       scl_i,
  output logic       scl_o,
  output logic       scl_t_o
);

  localparam int QW = $clog2(`IIC_QTR_CYCLES + 1);

  localparam logic [2:0] st_idle  = 3'd0;
  localparam logic [2:0] st_start = 3'd1;
  localparam logic [2:0] st_bit   = 3'd2;
  localparam logic [2:0] st_ack   = 3'd3;
  localparam logic [2:0] st_stop  = 3'd4;

  iic_op_s       op;
  logic [2:0]    state;
  logic [QW-1:0] qcnt;
  logic          tick;
  logic [1:0]    phase;
  logic [2:0]    bit_idx;
  logic          ack_bit;
  logic          sample;

  assign op     = op_word_i.f;
  assign tick   = qcnt == QW'(`IIC_QTR_CYCLES - 1);
  assign sample = (state == st_bit) && tick && (phase == 2'd1);

  // Open drain, only the enables toggle.
  assign scl_o = 1'b0;
  assign sda_o = 1'b0;

  always_ff @(posedge OPB_Clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      qcnt <= '0;
    end else if (state == st_idle || tick) begin
      qcnt <= '0;
    end else begin
      qcnt <= qcnt + 1'b1;
    end
  end

  // Read data shifts in MSB first, sampled mid SCL high.
  always_ff @(posedge OPB_Clk) begin
    if (sample) begin
      rd_data_o <= {rd_data_o[6:0], sda_i};
    end
  end

  always_ff @(posedge OPB_Clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state    <= st_idle;
      phase    <= 2'd0;
      bit_idx  <= 3'd7;
      ack_bit  <= 1'b0;
      scl_t_o  <= 1'b1;
      sda_t_o  <= 1'b1;
      op_ack_o <= 1'b0;
      nack_o   <= 1'b0;
    end else begin
      op_ack_o <= 1'b0;
      nack_o   <= 1'b0;
      case (state)
        st_idle: begin
          phase   <= 2'd0;
          bit_idx <= 3'd7;
          // Head is stale while its pop is in flight.
          if (op_valid_i && !op_ack_o) begin
            if (op.start) begin
              state   <= st_start;
              sda_t_o <= 1'b1;
            end else begin
              state   <= st_bit;
              sda_t_o <= op.rnw | op.data[7];
            end
          end
        end
        st_start: if (tick) begin
          phase <= phase + 2'd1;
          case (phase)
            2'd0: scl_t_o <= 1'b1;
            2'd1: begin
              if (scl_i) begin
                sda_t_o <= 1'b0;  // START, SDA falls with SCL high.
              end else begin
                phase <= phase;
              end
            end
            2'd2: scl_t_o <= 1'b0;
            default: begin
              state   <= st_bit;
              sda_t_o <= op.rnw | op.data[7];
            end
          endcase
        end
        st_bit: if (tick) begin
          phase <= phase + 2'd1;
          case (phase)
            2'd0: scl_t_o <= 1'b1;
            2'd2: scl_t_o <= 1'b0;
            2'd3: begin
              if (bit_idx == 3'd0) begin
                state   <= st_ack;
                sda_t_o <= !op.rnw | op.stop;  // Release for slave ack, or NACK the last read.
              end else begin
                bit_idx <= bit_idx - 3'd1;
                sda_t_o <= op.rnw | op.data[bit_idx - 3'd1];
              end
            end
            default: ;
          endcase
        end
        st_ack: if (tick) begin
          phase <= phase + 2'd1;
          case (phase)
            2'd0: scl_t_o <= 1'b1;
            2'd1: ack_bit <= sda_i;
            2'd2: scl_t_o <= 1'b0;
            default: begin
              bit_idx <= 3'd7;
              if (op.stop) begin
                state   <= st_stop;
                sda_t_o <= 1'b0;
              end else begin
                state    <= st_idle;
                sda_t_o  <= 1'b1;  // SCL stays low between bytes.
                op_ack_o <= 1'b1;
                nack_o   <= !op.rnw && ack_bit;
              end
            end
          endcase
        end
        st_stop: if (tick) begin
          phase <= phase + 2'd1;
          case (phase)
            2'd0: scl_t_o <= 1'b1;
            2'd1: sda_t_o <= 1'b1;  // STOP, SDA rises with SCL high.
            2'd3: begin
              state    <= st_idle;
              op_ack_o <= 1'b1;
              nack_o   <= !op.rnw && ack_bit;
            end
            default: ;
          endcase
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- iic_controller.sv
`timescale 1ns/10ps
`include "iic_defines.svh"

module iic_controller import iic_pkg::*; (
  input  logic        OPB_Clk,
  input  logic        rst_n_i,
  input  logic [31:0] opb_abus_i,
  input  logic [31:0] opb_dbus_i,
  input  logic        opb_rnw_i,
  input  logic [3:0]  opb_be_i,
  input  logic        opb_select_i,
  output logic [31:0] sl_dbus_o,
  output logic        sl_xferack_o,
  output logic        xfer_done_o,
  input  logic        sda_i,
  output logic        sda_o,
  output logic        sda_t_o,
  input  logic        scl_i,
  output logic        scl_o,
  output logic        scl_t_o
);

  iic_op_u    op_in;
  iic_op_u    op_head;
  logic       op_push;
  logic       op_empty;
  logic       op_full;
  logic       op_over;
  logic       op_ack;
  logic       nack;
  logic       rx_push;
  logic       rx_pop;
  logic [7:0] rx_head;
  logic [7:0] rd_data;
  logic       rx_empty;
  logic       rx_full;
  logic       rx_over;
  logic       op_empty_q;

  assign rx_push = op_ack && op_head.f.rnw;

  iic_opb_attach u_attach (
    .OPB_Clk      (OPB_Clk),
    .rst_n_i      (rst_n_i),
    .opb_abus_i   (opb_abus_i),
    .opb_dbus_i   (opb_dbus_i),
    .opb_rnw_i    (opb_rnw_i),
    .opb_be_i     (opb_be_i),
    .opb_select_i (opb_select_i),
    .sl_dbus_o    (sl_dbus_o),
    .sl_xferack_o (sl_xferack_o),
    .op_push_o    (op_push),
    .op_word_o    (op_in),
    .rx_pop_o     (rx_pop),
    .rx_data_i    (rx_head),
    .op_empty_i   (op_empty),
    .op_full_i    (op_full),
    .op_over_i    (op_over),
    .rx_empty_i   (rx_empty),
    .rx_full_i    (rx_full),
    .rx_over_i    (rx_over),
    .nack_i       (nack)
  );

  iic_sync_fifo #(.WIDTH(11), .DEPTH(`IIC_OP_DEPTH)) u_op_fifo (
    .OPB_Clk    (OPB_Clk),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (op_push),
    .din_i      (op_in),
    .rd_en_i    (op_ack),
    .dout_o     (op_head),
    .empty_o    (op_empty),
    .full_o     (op_full),
    .overflow_o (op_over)
  );

  iic_sync_fifo #(.WIDTH(8), .DEPTH(`IIC_RX_DEPTH)) u_rx_fifo (
    .OPB_Clk    (OPB_Clk),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (rx_push),
    .din_i      (rd_data),
    .rd_en_i    (rx_pop),
    .dout_o     (rx_head),
    .empty_o    (rx_empty),
    .full_o     (rx_full),
    .overflow_o (rx_over)
  );

  iic_byte_engine u_engine (
    .OPB_Clk    (OPB_Clk),
    .rst_n_i    (rst_n_i),
    .op_valid_i (!op_empty),
    .op_word_i  (op_head),
    .op_ack_o   (op_ack),
    .rd_data_o  (rd_data),
    .nack_o     (nack),
    .sda_i      (sda_i),
    .sda_o      (sda_o),
    .sda_t_o    (sda_t_o),
    .scl_i      (scl_i),
    .scl_o      (scl_o),
    .scl_t_o    (scl_t_o)
  );

  // Pulse once when the operation queue drains.
  always_ff @(posedge OPB_Clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_empty_q  <= 1'b1;
      xfer_done_o <= 1'b0;
    end else begin
      op_empty_q  <= op_empty;
      xfer_done_o <= op_empty && !op_empty_q;
    end
  end

endmodule

//--- iic_controller_chk.sv
`timescale 1ns/10ps

module iic_controller_chk (
  input logic        OPB_Clk,
  input logic        rst_n_i,
  input logic        sl_xferack_i,
  input logic [31:0] sl_dbus_i,
  input logic        scl_t_i,
  input logic        sda_t_i,
  input logic        op_empty_i
);

  int unsigned assert_fails = 0;
  logic        op_seen;

  always_ff @(posedge OPB_Clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_seen <= 1'b0;
    end else if (!op_empty_i) begin
      op_seen <= 1'b1;  // First operation reached the engine.
    end
  end

  ack_single: assert property (@(posedge OPB_Clk) disable iff (!rst_n_i)
    sl_xferack_i |=> !sl_xferack_i)
    else begin
      assert_fails++;
      $error("Bus acknowledge high on two cycles in a row");
    end

  dbus_quiet: assert property (@(posedge OPB_Clk) disable iff (!rst_n_i)
    !sl_xferack_i |-> (sl_dbus_i == 32'h0))
    else begin
      assert_fails++;
      $error("Read data bus not zero outside an acknowledge");
    end

  pins_released: assert property (@(posedge OPB_Clk) disable iff (!rst_n_i)
    !op_seen |-> (scl_t_i && sda_t_i))
    else begin
      assert_fails++;
      $error("Bus pins driven before any operation was queued");
    end

endmodule

//--- tb_iic_controller.sv
`timescale 1ns/10ps
`include "iic_defines.svh"

module tb_iic_controller import iic_pkg::*; ();

  localparam logic [31:0] idle_stat = (32'd1 << stat_op_empty) | (32'd1 << stat_rx_empty);

  logic        OPB_Clk;
  logic        rst_n_i;
  logic [31:0] opb_abus;
  logic [31:0] opb_dbus;
  logic        opb_rnw;
  logic [3:0]  opb_be;
  logic        opb_select;
  logic [31:0] sl_dbus;
  logic        sl_xferack;
  logic        xfer_done;
  logic        sda_o;
  logic        sda_t;
  logic        scl_o;
  logic        scl_t;
  logic        sda_line;
  logic        scl_line;
  logic        slave_sda = 1'b1;
  logic        rd_mode = 1'b0;
  logic        mst_nack = 1'b1;
  logic [7:0]  shift_reg;
  logic [7:0]  tx_byte;
  logic [7:0]  wr_q[$];   // Bytes seen by the slave model.
  logic [7:0]  exp_q[$];  // Bytes the slave should see.
  integer      seed = 99233;
  string       test_name = "";
  int          done_cnt = 0;
  int          start_cnt = 0;
  int          stop_cnt = 0;
  int          bit_cnt = 0;
  int          rd_idx = 0;
  int          exp_rd_idx = 0;

  // Open-drain lines with pull-ups.
  assign scl_line = scl_t ? 1'b1 : scl_o;
  assign sda_line = (sda_t ? 1'b1 : sda_o) & slave_sda;

  iic_controller i_iic_controller (
    .OPB_Clk      (OPB_Clk),
    .rst_n_i      (rst_n_i),
    .opb_abus_i   (opb_abus),
    .opb_dbus_i   (opb_dbus),
    .opb_rnw_i    (opb_rnw),
    .opb_be_i     (opb_be),
    .opb_select_i (opb_select),
    .sl_dbus_o    (sl_dbus),
    .sl_xferack_o (sl_xferack),
    .xfer_done_o  (xfer_done),
    .sda_i        (sda_line),
    .sda_o        (sda_o),
    .sda_t_o      (sda_t),
    .scl_i        (scl_line),
    .scl_o        (scl_o),
    .scl_t_o      (scl_t)
  );

  bind iic_controller iic_controller_chk u_chk (
    .OPB_Clk      (OPB_Clk),
    .rst_n_i      (rst_n_i),
    .sl_xferack_i (sl_xferack_o),
    .sl_dbus_i    (sl_dbus_o),
    .scl_t_i      (scl_t_o),
    .sda_t_i      (sda_t_o),
    .op_empty_i   (op_empty)
  );

  always #2 OPB_Clk = ~OPB_Clk;

  function automatic logic [7:0] slave_byte(input int n);
    return 8'(n * 37 + 5);
  endfunction

  function automatic iic_op_u make_op(input logic stop, input logic start, input logic rnw,
                                      input logic [7:0] data);
    iic_op_u op;
    op.f.stop  = stop;
    op.f.start = start;
    op.f.rnw   = rnw;
    op.f.data  = data;
    return op;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [1:0] idx);
    return `IIC_BASEADDR + {28'b0, idx, 2'b00};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = 8'($random(seed));
    if (b == 8'hFF) begin
      b = 8'h5A;  // The slave would NACK this one.
    end
    return b;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s expected 8'h%02h actual 8'h%02h", name, exp, act));
    end
  endtask

  task automatic check_stat(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s expected 32'h%08h actual 32'h%08h", name, exp, act));
    end
  endtask

  task automatic check_pulse(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] wdata, input logic rnw,
                           output logic [31:0] rdata);
    int cnt;
    opb_abus   = addr;
    opb_dbus   = wdata;
    opb_rnw    = rnw;
    opb_be     = 4'b0001;
    opb_select = 1'b1;
    cnt        = 0;
    do begin
      @(negedge OPB_Clk);
      cnt++;
    end while (!sl_xferack && cnt < 16);
    if (!sl_xferack) begin
      abort_run($sformatf("%s: no bus acknowledge for address %08h", test_name, addr));
    end else begin
      rdata = sl_dbus;
      @(negedge OPB_Clk);  // Hold through the ack cycle.
      opb_select = 1'b0;
      opb_rnw    = 1'b0;
    end
  endtask

  task automatic opb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(addr, data, 1'b0, unused);
  endtask

  task automatic opb_read(input logic [31:0] addr, output logic [31:0] data);
    bus_cycle(addr, 32'h0, 1'b1, data);
  endtask

  task automatic push_op(input iic_op_u op);
    opb_write(reg_addr(`IIC_REG_OP), {21'b0, op.raw});
  endtask

  task automatic begin_seq(input string name, input logic reading);
    test_name = name;
    rd_mode   = reading;
    start_cnt = 0;
    stop_cnt  = 0;
  endtask

  // Waits for the drain pulse, then makes sure it came only once.
  task automatic finish_seq();
    int cnt;
    cnt = 0;
    while (done_cnt == 0 && cnt < 20000) begin
      @(negedge OPB_Clk);
      cnt++;
    end
    if (done_cnt == 0) begin
      abort_run($sformatf("%s: xfer_done never pulsed", test_name));
    end else if (exp_q.size() != 0) begin
      abort_run($sformatf("%s: slave model did not see every written byte", test_name));
    end else begin
      repeat (32) @(negedge OPB_Clk);
      check_pulse({test_name, " xfer_done"}, 1, done_cnt);
      check_pulse({test_name, " START count"}, 1, start_cnt);
      check_pulse({test_name, " STOP count"}, 1, stop_cnt);
      done_cnt = 0;
    end
  endtask

  always @(negedge OPB_Clk) begin
    if (xfer_done) begin
      done_cnt++;
    end
  end

  // A failed bound assertion ends the run at once.
  always @(negedge OPB_Clk) begin
    if (i_iic_controller.u_chk.assert_fails != 0) begin
      abort_run("A bound assertion failed during the run");
    end
  end

  // Written bytes are compared as the slave model collects them.
  always @(negedge OPB_Clk) begin
    if (wr_q.size() != 0) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("%s: slave model got a byte that was never queued", test_name));
      end else begin
        check_byte({test_name, " written byte"}, exp_q.pop_front(), wr_q.pop_front());
      end
    end
  end

  always @(negedge sda_line) begin
    if (rst_n_i === 1'b1 && scl_line === 1'b1) begin
      start_cnt++;
      bit_cnt = 0;
    end
  end

  always @(posedge sda_line) begin
    if (rst_n_i === 1'b1 && scl_line === 1'b1) begin
      stop_cnt++;
      bit_cnt = 0;
    end
  end

  always @(posedge scl_line) begin
    if (bit_cnt < 8) begin
      shift_reg = {shift_reg[6:0], sda_line};
    end else if (bit_cnt == 8) begin
      mst_nack = sda_line;  // Master acknowledge of a read byte.
    end
    bit_cnt++;
  end

  always @(negedge scl_line) begin
    if (bit_cnt == 9) begin
      bit_cnt   = 0;
      slave_sda = 1'b1;
      if (rd_mode && !mst_nack) begin
        tx_byte   = slave_byte(rd_idx);
        rd_idx++;
        slave_sda = tx_byte[7];
      end
    end else if (bit_cnt == 8) begin
      if (rd_mode) begin
        slave_sda = 1'b1;
      end else begin
        wr_q.push_back(shift_reg);
        slave_sda = (shift_reg == 8'hFF);  // NACK only 8'hFF.
      end
    end else if (rd_mode) begin
      if (bit_cnt == 0) begin
        tx_byte = slave_byte(rd_idx);
        rd_idx++;
      end
      slave_sda = tx_byte[7 - bit_cnt];
    end
  end

  initial begin
    logic [31:0] rdata;
    logic [7:0]  b;
    int          k;
    OPB_Clk    = 1'b0;
    rst_n_i    = 1'b0;
    opb_abus   = 32'h0;
    opb_dbus   = 32'h0;
    opb_rnw    = 1'b0;
    opb_be     = 4'b0000;
    opb_select = 1'b0;
    repeat (16) @(posedge OPB_Clk);
    @(negedge OPB_Clk);
    rst_n_i = 1'b1;
    repeat (4) @(negedge OPB_Clk);

    test_name = "reset status";
    opb_read(reg_addr(`IIC_REG_STATUS), rdata);
    check_stat(test_name, idle_stat, rdata);

    begin_seq("write burst", 1'b0);
    for (k = 0; k < 6; k++) begin
      b = rand_byte();
      exp_q.push_back(b);
      push_op(make_op(k == 5, k == 0, 1'b0, b));
    end
    finish_seq();

    begin_seq("read burst", 1'b1);
    for (k = 0; k < 4; k++) begin
      push_op(make_op(k == 3, k == 0, 1'b1, 8'h00));
    end
    finish_seq();
    for (k = 0; k < 4; k++) begin
      opb_read(reg_addr(`IIC_REG_RX), rdata);
      check_byte(test_name, slave_byte(exp_rd_idx), rdata[7:0]);
      exp_rd_idx++;
    end
    opb_read(reg_addr(`IIC_REG_STATUS), rdata);
    check_stat(test_name, idle_stat, rdata);

    begin_seq("nack", 1'b0);
    exp_q.push_back(8'hFF);
    push_op(make_op(1'b1, 1'b1, 1'b0, 8'hFF));
    finish_seq();
    opb_read(reg_addr(`IIC_REG_STATUS), rdata);
    check_stat(test_name, idle_stat | (32'd1 << stat_nack_err), rdata);
    opb_write(reg_addr(`IIC_REG_STATUS), 32'h0);
    opb_read(reg_addr(`IIC_REG_STATUS), rdata);
    check_stat({test_name, " cleared"}, idle_stat, rdata);

    begin_seq("overflow", 1'b0);
    for (k = 0; k < `IIC_OP_DEPTH + 4; k++) begin
      b = rand_byte();
      if (k <= `IIC_OP_DEPTH) begin
        exp_q.push_back(b);  // Queue plus head register hold DEPTH + 1.
      end
      push_op(make_op(k == `IIC_OP_DEPTH, k == 0, 1'b0, b));
    end
    opb_read(reg_addr(`IIC_REG_STATUS), rdata);
    check_stat(test_name, (32'd1 << stat_op_full) | (32'd1 << stat_op_over)
                          | (32'd1 << stat_rx_empty), rdata);
    finish_seq();
    opb_write(reg_addr(`IIC_REG_STATUS), 32'h0);
    opb_read(reg_addr(`IIC_REG_STATUS), rdata);
    check_stat({test_name, " cleared"}, idle_stat, rdata);

    if (i_iic_controller.u_chk.assert_fails != 0) begin
      abort_run("A bound assertion failed during the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- iic_controller.f
+incdir+.
iic_pkg.sv
iic_sync_fifo.sv
iic_opb_attach.sv
iic_byte_engine.sv
iic_controller.sv
iic_controller_chk.sv
tb_iic_controller.sv

//--- Bender.yml
package:
  name: iic_controller

sources:
  - include_dirs:
      - .
    files:
      - iic_pkg.sv
      - iic_sync_fifo.sv
      - iic_opb_attach.sv
      - iic_byte_engine.sv
      - iic_controller.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - iic_controller_chk.sv
      - tb_iic_controller.sv
